// ==== rtl/rate_cfg_pkg.sv ====
`default_nettype none

package rate_cfg_pkg;

  // ------------------------------------------------------------------------
  // Lane and counter sizing
  // ------------------------------------------------------------------------

  // Number of event lanes sampled each cycle
  localparam int num_lanes = 4;

  // Largest counter value, inclusive, so the counter wraps modulo 10
  localparam int max_value = 9;

  // At most every lane fires in one cycle
  localparam int max_increment = num_lanes;

  // Bit widths derived from the inclusive limits above
  localparam int value_width = $clog2(max_value + 1);
  localparam int incr_width = $clog2(max_increment + 1);
  localparam int wrap_count_width = 8;

  // State the counter takes out of reset
  localparam int reset_value = 0;

endpackage : rate_cfg_pkg

`default_nettype wire

// ==== rtl/rate_types_pkg.sv ====
`default_nettype none

package rate_types_pkg;

  import rate_cfg_pkg::*;

  // ------------------------------------------------------------------------
  // Data types shared across the design
  // ------------------------------------------------------------------------

  // Counter value in the range 0 to max_value
  typedef logic [value_width-1:0] value_t;

  // Number of set lanes in one cycle, 0 to max_increment
  typedef logic [incr_width-1:0] incr_t;

  // One bit per event lane
  typedef logic [num_lanes-1:0] lanes_t;

  // Count of counter wraps, rolls over on its own
  typedef logic [wrap_count_width-1:0] wrap_count_t;

endpackage : rate_types_pkg

`default_nettype wire

// ==== rtl/incr_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Increment request from the lane encoder to the counter
// All four signals are registered levels and the counter
// applies them on the next rising edge of the clock
interface incr_if;

  import rate_types_pkg::*;

  // Set when at least one sampled lane was set
  logic   incr_valid;

  // Population count of the sampled lanes
  incr_t  incr;

  // Reload strobe, the increment still applies on top of initial_value
  logic   reinit;

  // Value loaded on reinit
  value_t initial_value;

  // Lane encoder side
  modport producer (
    output incr_valid,
    output incr,
    output reinit,
    output initial_value
  );

  // Counter side
  modport consumer (
    input incr_valid,
    input incr,
    input reinit,
    input initial_value
  );

endinterface : incr_if

`default_nettype wire

// ==== rtl/lane_event_encoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module lane_event_encoder (
  input  logic                   clk,
  input  logic                   arst_n,
  input  rate_types_pkg::lanes_t lanes,
  input  logic                   reinit,
  input  rate_types_pkg::value_t initial_value,
  incr_if.producer               incr_bus
);

  import rate_cfg_pkg::*;
  import rate_types_pkg::*;

  lanes_t lanes_q;
  logic   reinit_q;
  value_t initial_value_q;
  incr_t  lane_count;

  // ------------------------------------------------------------------------
  // Input registers
  // ------------------------------------------------------------------------

  // Lanes and reinit are cleared so no increment is seen after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lanes_q  <= '0;
      reinit_q <= 1'b0;
    end else begin
      lanes_q  <= lanes;
      reinit_q <= reinit;
    end
  end

  // The initial value is only looked at while reinit_q is high
  always_ff @(posedge clk) begin
    initial_value_q <= initial_value;
  end

  // ------------------------------------------------------------------------
  // Lane count
  // ------------------------------------------------------------------------

  // Add up the set lanes, at most num_lanes which fits in incr_t
  always_comb begin
    lane_count = '0;
    for (int i = 0; i < num_lanes; i++) begin
      lane_count = lane_count + incr_t'(lanes_q[i]);
    end
  end

  // A zero count is not worth an update, so valid follows a nonzero count
  assign incr_bus.incr          = lane_count;
  assign incr_bus.incr_valid    = (lane_count != '0);
  assign incr_bus.reinit        = reinit_q;
  assign incr_bus.initial_value = initial_value_q;

endmodule : lane_event_encoder

`default_nettype wire

// ==== rtl/counter_incr.sv ====
`default_nettype none
`timescale 1ns/1ps

module counter_incr (
  input  logic                   clk,
  input  logic                   arst_n,
  incr_if.consumer               incr_bus,
  output rate_types_pkg::value_t value,
  output logic                   wrap,
  output logic                   restart
);

  import rate_cfg_pkg::*;
  import rate_types_pkg::*;

  // One extra bit holds the largest sum, max_value plus max_increment
  logic [value_width:0] sum;
  value_t               base;
  incr_t                incr_eff;
  value_t               value_next;
  logic                 overflow;
  logic                 update;

  // ------------------------------------------------------------------------
  // Next value
  // ------------------------------------------------------------------------

  // On reinit the increment lands on initial_value instead of the old value
  assign base     = incr_bus.reinit ? incr_bus.initial_value : value;
  assign incr_eff = incr_bus.incr_valid ? incr_bus.incr : '0;

  assign sum = (value_width + 1)'(base) + (value_width + 1)'(incr_eff);

  // 10 is not a power of two, so the wrap has to be taken by hand
  assign overflow = (sum > (value_width + 1)'(max_value));

  always_comb begin
    if (overflow) begin
      value_next = value_t'(sum - (value_width + 1)'(max_value + 1));
    end else begin
      value_next = value_t'(sum);
    end
  end

  // Hold the value when there is nothing to add and no reload
  assign update = incr_bus.incr_valid || incr_bus.reinit;

  // ------------------------------------------------------------------------
  // State
  // ------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= value_t'(reset_value);
    end else if (update) begin
      value <= value_next;
    end
  end

  // Both flags are one-cycle pulses that line up with the new value
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wrap    <= 1'b0;
      restart <= 1'b0;
    end else begin
      wrap    <= update && overflow;
      restart <= incr_bus.reinit;
    end
  end

endmodule : counter_incr

`default_nettype wire

// ==== rtl/wrap_tick_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module wrap_tick_gen (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        wrap,
  input  logic                        restart,
  output logic                        tick,
  output rate_types_pkg::wrap_count_t wrap_count
);

  import rate_cfg_pkg::*;
  import rate_types_pkg::*;

  wrap_count_t wrap_count_next;

  // ------------------------------------------------------------------------
  // Wrap count
  // ------------------------------------------------------------------------

  // A restart drops the old history, but a reload that wrapped
  // already counts as the first wrap of the new run
  always_comb begin
    if (restart) begin
      wrap_count_next = wrap_count_t'(wrap);
    end else if (wrap) begin
      // Rolls over from 255 to 0 with no extra logic
      wrap_count_next = wrap_count + wrap_count_width'(1);
    end else begin
      wrap_count_next = wrap_count;
    end
  end

  // ------------------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tick       <= 1'b0;
      wrap_count <= '0;
    end else begin
      tick       <= wrap;
      wrap_count <= wrap_count_next;
    end
  end

endmodule : wrap_tick_gen

`default_nettype wire

// ==== rtl/event_rate_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module event_rate_top (
  input  logic                        clk,
  input  logic                        arst_n,
  input  rate_types_pkg::lanes_t      lanes,
  input  logic                        reinit,
  input  rate_types_pkg::value_t      initial_value,
  output rate_types_pkg::value_t      value,
  output logic                        tick,
  output rate_types_pkg::wrap_count_t wrap_count
);

  // Pulses from the counter to the tick stage
  logic wrap;
  logic restart;

  // Increment link between encoder and counter
  incr_if incr_bus ();

  // Stage 1 registers the lanes and counts them
  lane_event_encoder u_lane_event_encoder (
    .clk           (clk),
    .arst_n        (arst_n),
    .lanes         (lanes),
    .reinit        (reinit),
    .initial_value (initial_value),
    .incr_bus      (incr_bus.producer)
  );

  // Stage 2 is the modulo-10 counter
  counter_incr u_counter_incr (
    .clk      (clk),
    .arst_n   (arst_n),
    .incr_bus (incr_bus.consumer),
    .value    (value),
    .wrap     (wrap),
    .restart  (restart)
  );

  // Stage 3 turns wraps into ticks and counts them
  wrap_tick_gen u_wrap_tick_gen (
    .clk        (clk),
    .arst_n     (arst_n),
    .wrap       (wrap),
    .restart    (restart),
    .tick       (tick),
    .wrap_count (wrap_count)
  );

endmodule : event_rate_top

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  // Free running clock with a 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset is held over the first four rising edges
  // The release lands after those edges have seen reset low
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== dv/tb_rate_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_rate_checker (
  input  logic                        clk,
  input  logic                        arst_n,
  input  rate_types_pkg::value_t      value,
  input  logic                        tick,
  input  rate_types_pkg::wrap_count_t wrap_count,
  input  logic                        exp_check,
  input  logic                        exp_hold,
  input  logic [3:0]                  exp_id,
  input  rate_types_pkg::value_t      exp_value,
  input  logic                        exp_tick,
  input  rate_types_pkg::wrap_count_t exp_wrap_count,
  output int                          error_count,
  output logic                        pending
);

  import rate_cfg_pkg::*;
  import rate_types_pkg::*;

  // Stage n holds the expectation of the entry driven n rising edges ago
  logic        chk_q   [1:3];
  logic        hold_q  [1:3];
  logic [3:0]  id_q    [1:3];
  value_t      value_q [1:3];
  logic        tick_q  [1:3];
  wrap_count_t wc_q    [1:3];

  // Last checked state, which an idle gap has to keep
  value_t      last_value = value_t'(reset_value);
  wrap_count_t last_wc = '0;
  logic        reset_checked = 1'b0;

  initial error_count = 0;

  // Anything still waiting to be compared
  assign pending = chk_q[1] || chk_q[2] || chk_q[3];

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1: return "reset";
      4'd2: return "accumulate";
      4'd3: return "wrap_crossing";
      4'd4: return "reinit";
      4'd5: return "rollover";
      4'd6: return "zero_lanes";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare_field(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %0d, actual %0d", name, field, expected, actual);
      error_count++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Latency pipeline
  // ------------------------------------------------------------------------

  // Value shows up two edges after the drive, tick and wrap count three
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i <= 3; i++) begin
        chk_q[i]  <= 1'b0;
        hold_q[i] <= 1'b0;
      end
    end else begin
      chk_q[1]   <= exp_check;
      hold_q[1]  <= exp_hold;
      id_q[1]    <= exp_id;
      value_q[1] <= exp_value;
      tick_q[1]  <= exp_tick;
      wc_q[1]    <= exp_wrap_count;
      for (int i = 2; i <= 3; i++) begin
        chk_q[i]   <= chk_q[i-1];
        hold_q[i]  <= hold_q[i-1];
        id_q[i]    <= id_q[i-1];
        value_q[i] <= value_q[i-1];
        tick_q[i]  <= tick_q[i-1];
        wc_q[i]    <= wc_q[i-1];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Comparison on the falling edge, where the outputs are settled
  // ------------------------------------------------------------------------

  always @(negedge clk) begin
    string name;
    if (arst_n) begin
      if (!reset_checked) begin
        compare_field("reset", "value", 32'(reset_value), 32'(value));
        compare_field("reset", "tick", 32'd0, 32'(tick));
        compare_field("reset", "wrap_count", 32'd0, 32'(wrap_count));
        reset_checked = 1'b1;
      end
      if (chk_q[2]) begin
        name = test_name(id_q[2]);
        if (hold_q[2]) begin
          compare_field({name, " gap"}, "value", 32'(last_value), 32'(value));
        end else begin
          compare_field(name, "value", 32'(value_q[2]), 32'(value));
          last_value = value_q[2];
        end
      end
      if (chk_q[3]) begin
        name = test_name(id_q[3]);
        if (hold_q[3]) begin
          // An idle cycle never wraps, so no tick and the count stays
          compare_field({name, " gap"}, "tick", 32'd0, 32'(tick));
          compare_field({name, " gap"}, "wrap_count", 32'(last_wc), 32'(wrap_count));
        end else begin
          compare_field(name, "tick", 32'(tick_q[3]), 32'(tick));
          compare_field(name, "wrap_count", 32'(wc_q[3]), 32'(wrap_count));
          last_wc = wc_q[3];
        end
      end
    end
  end

endmodule : tb_rate_checker

`default_nettype wire

// ==== dv/event_rate_props.sv ====
`default_nettype none
`timescale 1ns/1ps

module event_rate_props (
  input logic                             clk,
  input logic                             arst_n,
  input rate_types_pkg::value_t           value,
  input logic                             incr_valid,
  input rate_types_pkg::incr_t            incr,
  input logic                             reinit,
  input rate_types_pkg::value_t           initial_value,
  input logic                             wrap
);

  import rate_cfg_pkg::*;

  // Number of failed assertions, read back at the end of the run
  int fail_count = 0;

  // Unbounded sum of an update, the base plus the lane count
  int update_sum;

  assign update_sum = (reinit ? int'(initial_value) : int'(value)) + int'(incr);

  // The counter never leaves the range 0 to max_value
  value_in_range_a : assert property (@(posedge clk) disable iff (!arst_n)
    value <= max_value)
  else begin
    fail_count++;
    $error("counter value is above max_value");
  end

  // A reload with nothing to add lands exactly on initial_value
  reinit_loads_a : assert property (@(posedge clk) disable iff (!arst_n)
    (reinit && !incr_valid) |=> (value == $past(initial_value)))
  else begin
    fail_count++;
    $error("reinit without increment did not load initial_value");
  end

  // Wrap is only raised for an update whose sum went past max_value
  wrap_needs_overflow_a : assert property (@(posedge clk) disable iff (!arst_n)
    wrap |-> ($past(update_sum) > max_value))
  else begin
    fail_count++;
    $error("wrap raised without a sum above max_value");
  end

endmodule : event_rate_props

bind counter_incr event_rate_props u_counter_props (
  .clk           (clk),
  .arst_n        (arst_n),
  .value         (value),
  .incr_valid    (incr_bus.incr_valid),
  .incr          (incr_bus.incr),
  .reinit        (incr_bus.reinit),
  .initial_value (incr_bus.initial_value),
  .wrap          (wrap)
);

`default_nettype wire

// ==== dv/tb_event_rate_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_event_rate_top;

  import rate_cfg_pkg::*;
  import rate_types_pkg::*;

  // Eight hex words per data line, up to 32 lines
  parameter int max_lines = 32;
  parameter int words_per_line = 8;

  logic        clk;
  logic        arst_n;
  lanes_t      lanes;
  logic        reinit;
  value_t      initial_value;
  value_t      value;
  logic        tick;
  wrap_count_t wrap_count;

  // Expectation that travels with each driven entry
  logic        exp_check;
  logic        exp_hold;
  logic [3:0]  exp_id;
  value_t      exp_value;
  logic        exp_tick;
  wrap_count_t exp_wrap_count;

  int          error_count;
  logic        pending;
  int          other_errors;
  logic [11:0] stim_mem [0:max_lines*words_per_line-1];

  tb_clock_gen u_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  event_rate_top dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .lanes         (lanes),
    .reinit        (reinit),
    .initial_value (initial_value),
    .value         (value),
    .tick          (tick),
    .wrap_count    (wrap_count)
  );

  tb_rate_checker u_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .value          (value),
    .tick           (tick),
    .wrap_count     (wrap_count),
    .exp_check      (exp_check),
    .exp_hold       (exp_hold),
    .exp_id         (exp_id),
    .exp_value      (exp_value),
    .exp_tick       (exp_tick),
    .exp_wrap_count (exp_wrap_count),
    .error_count    (error_count),
    .pending        (pending)
  );

  // ------------------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------------------

  // One DUT cycle of input together with what the checker should expect
  task automatic drive_entry(input lanes_t l, input logic r, input value_t iv,
                             input logic chk, input logic hold, input logic [3:0] id,
                             input value_t ev, input logic et, input wrap_count_t ew);
    @(posedge clk);
    lanes          <= l;
    reinit         <= r;
    initial_value  <= iv;
    exp_check      <= chk;
    exp_hold       <= hold;
    exp_id         <= id;
    exp_value      <= ev;
    exp_tick       <= et;
    exp_wrap_count <= ew;
  endtask

  task automatic wait_for_reset_release(output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < 20) begin
      @(negedge clk);
      ok = arst_n;
      cycles++;
    end
    if (!ok) begin
      $display("Timeout: reset was never released");
      other_errors++;
    end
  endtask

  task automatic wait_for_checker_drain(output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < 50) begin
      @(negedge clk);
      ok = !pending;
      cycles++;
    end
    if (!ok) begin
      $display("Timeout: checker still had entries waiting for comparison");
      other_errors++;
    end
  endtask

  // Each line is applied repeat times, and only its last cycle is checked
  // A random run of zero-lane cycles follows, checked for holding state
  task automatic play_stimulus();
    int  line_idx;
    int  base;
    int  rep;
    int  gap_len;
    bit  done;
    line_idx = 0;
    done = 1'b0;
    if ($isunknown(stim_mem[0]) || stim_mem[0] == '0) begin
      $display("No stimulus lines were read from the data file");
      other_errors++;
    end
    while (!done && line_idx < max_lines) begin
      base = line_idx * words_per_line;
      if ($isunknown(stim_mem[base]) || stim_mem[base] == '0) begin
        done = 1'b1;
      end else begin
        rep = stim_mem[base+1];
        for (int r = 1; r <= rep; r++) begin
          drive_entry(lanes_t'(stim_mem[base+2]), stim_mem[base+3][0],
                      value_t'(stim_mem[base+4]), (r == rep), 1'b0,
                      stim_mem[base][3:0], value_t'(stim_mem[base+5]),
                      stim_mem[base+6][0], wrap_count_t'(stim_mem[base+7]));
        end
        gap_len = $urandom % 4;
        for (int g = 0; g < gap_len; g++) begin
          drive_entry('0, 1'b0, '0, 1'b1, 1'b1, stim_mem[base][3:0], '0, 1'b0, '0);
        end
        line_idx++;
      end
    end
    drive_entry('0, 1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic report_result();
    int assert_errors;
    assert_errors = dut.u_counter_incr.u_counter_props.fail_count;
    $display("Errors: %0d compare, %0d assertion, %0d other",
             error_count, assert_errors, other_errors);
    if (error_count == 0 && assert_errors == 0 && other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------

  initial begin
    int seed_ret;
    bit ok;
    lanes          = '0;
    reinit         = 1'b0;
    initial_value  = '0;
    exp_check      = 1'b0;
    exp_hold       = 1'b0;
    exp_id         = '0;
    exp_value      = '0;
    exp_tick       = 1'b0;
    exp_wrap_count = '0;
    other_errors   = 0;
    seed_ret = $urandom(32'hb4bb);
    $readmemh("dv/event_rate_testdata.txt", stim_mem);
    wait_for_reset_release(ok);
    if (ok) begin
      play_stimulus();
      wait_for_checker_drain(ok);
    end
    report_result();
  end

endmodule : tb_event_rate_top

`default_nettype wire

// ==== compile.f ====
rtl/rate_cfg_pkg.sv
rtl/rate_types_pkg.sv
rtl/incr_if.sv
rtl/lane_event_encoder.sv
rtl/counter_incr.sv
rtl/wrap_tick_gen.sv
rtl/event_rate_top.sv
dv/tb_clock_gen.sv
dv/tb_rate_checker.sv
dv/event_rate_props.sv
dv/tb_event_rate_top.sv

// ==== dv/event_rate_testdata.txt ====
// Columns in hex: test_id repeat lanes reinit initial_value exp_value exp_tick exp_wrap_count
// Expected columns give the state after the line's last cycle, test_id 0 ends the list
1 001 0 0 0 0 0 00
2 001 1 0 0 1 0 00
2 001 3 0 0 3 0 00
2 001 7 0 0 6 0 00
2 001 0 0 0 6 0 00
2 001 8 0 0 7 0 00
2 001 6 0 0 9 0 00
2 001 2 0 0 0 1 01
3 001 F 0 0 4 0 01
3 001 F 0 0 8 0 01
3 001 F 0 0 2 1 02
3 001 5 0 0 4 0 02
3 001 D 0 0 7 0 02
3 001 B 0 0 0 1 03
4 001 3 1 5 7 0 00
4 001 F 0 0 1 1 01
4 001 7 1 8 1 1 01
4 001 0 1 9 9 0 00
6 001 0 0 0 9 0 00
6 001 0 0 0 9 0 00
5 001 0 1 0 0 0 00
5 27E F 0 0 2 1 FF
5 002 F 0 0 0 1 00
0 000 0 0 0 0 0 00
